// File: design/r5p_mini_cfg.svh
`ifndef R5P_MINI_CFG_SVH
`define R5P_MINI_CFG_SVH
`default_nettype none

// data path width
`define R5P_XLEN 32
// register address width, 4 gives an RV32E style file
`define R5P_AW 5
// shift amount width follows from the data width
`define R5P_SHW $clog2(`R5P_XLEN)

`default_nettype wire
`endif

// File: design/r5p_mini_pkg.sv
`default_nettype none

package r5p_mini_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // operations
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    op_add  = 4'd0,  // rs1 + op b
    op_sub  = 4'd1,  // rs1 - op b
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_slt  = 4'd5,  // signed compare
    op_sltu = 4'd6,  // unsigned compare
    op_sll  = 4'd7,  // bit serial, one bit per cycle
    op_srl  = 4'd8,
    op_sra  = 4'd9   // fills with sign bit
  } alu_op_t;

  // shifts run through the counter, everything else is single cycle
  function automatic logic is_shift(alu_op_t op);
    return (op == op_sll) || (op == op_srl) || (op == op_sra);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // control sequencer states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    st_idle = 2'd0,  // waiting for ins_valid
    st_read = 2'd1,  // gpr read phase
    st_exec = 2'd2,  // compute, shifts stay here
    st_wb   = 2'd3   // writeback and retire
  } ctl_state_t;

endpackage : r5p_mini_pkg

`default_nettype wire

// File: design/r5p_mini_rf_if.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

// register file access bundle, ctl steers it, gpr and alu move the data
interface r5p_mini_rf_if;

  // read/write enables
  logic                 e_rs1;
  logic                 e_rs2;
  logic                 e_rd;
  // read/write addresses
  logic [`R5P_AW-1:0]   a_rs1;
  logic [`R5P_AW-1:0]   a_rs2;
  logic [`R5P_AW-1:0]   a_rd;
  // read/write data
  logic [`R5P_XLEN-1:0] d_rs1;
  logic [`R5P_XLEN-1:0] d_rs2;
  logic [`R5P_XLEN-1:0] d_rd;

  // sequencer side, owns all enables and addresses
  modport ctl (
    output e_rs1, e_rs2, e_rd,
    output a_rs1, a_rs2, a_rd
  );

  // storage side
  modport gpr (
    input  e_rs1, e_rs2, e_rd,
    input  a_rs1, a_rs2, a_rd,
    input  d_rd,
    output d_rs1, d_rs2
  );

  // datapath side
  modport alu (
    input  d_rs1, d_rs2,
    output d_rd
  );

endinterface : r5p_mini_rf_if

`default_nettype wire

// File: design/r5p_mini_gpr.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_gpr (
  input  logic clk,
  input  logic reset,
  r5p_mini_rf_if.gpr rf
);

  localparam int unsigned NREG = 2**`R5P_AW;  // 32, or 16 for RV32E

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  logic [`R5P_XLEN-1:0] regs [NREG];

  logic                 wen;    // qualified write enable
  logic [`R5P_XLEN-1:0] t_rs1;  // raw array reads
  logic [`R5P_XLEN-1:0] t_rs2;

  // x0 is hardwired, writes to it just vanish
  assign wen = rf.e_rd & (|rf.a_rd);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;  // whole file clears
      end
    end else if (wen) begin
      regs[rf.a_rd] <= rf.d_rd;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // asynchronous read ports
  ////////////////////////////////////////////////////////////////////////////

  assign t_rs1 = regs[rf.a_rs1];
  assign t_rs2 = regs[rf.a_rs2];

  // port reads zero when idle or when x0 is addressed
  always_comb begin
    if (rf.e_rs1 && (rf.a_rs1 != '0)) begin
      rf.d_rs1 = t_rs1;
    end else begin
      rf.d_rs1 = '0;
    end
  end

  always_comb begin
    if (rf.e_rs2 && (rf.a_rs2 != '0)) begin
      rf.d_rs2 = t_rs2;
    end else begin
      rf.d_rs2 = '0;
    end
  end

  // no bypass here
  // writeback lands on the edge that opens the next read phase,
  // so a read never overlaps a write of the same cycle

endmodule : r5p_mini_gpr

`default_nettype wire

// File: design/r5p_mini_ctl.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_ctl (
  input  logic                  clk,
  input  logic                  reset,
  // instruction side
  input  logic                  ins_valid,
  input  r5p_mini_pkg::alu_op_t op,
  input  logic [`R5P_AW-1:0]    rd,
  input  logic [`R5P_AW-1:0]    rs1,
  input  logic [`R5P_AW-1:0]    rs2,
  // from shift counter
  input  logic                  cnt_zero,
  // handshake and retire
  output logic                  busy,
  output logic                  ret,
  output logic [`R5P_AW-1:0]    ret_rd,
  // datapath steering
  output logic                  cap,
  output logic                  load,
  output logic                  step,
  output r5p_mini_pkg::alu_op_t op_q,
  r5p_mini_rf_if.ctl            rf
);

  import r5p_mini_pkg::*;

  ctl_state_t         state;
  logic               accept;  // instruction taken at this edge
  logic [`R5P_AW-1:0] rd_q;    // current instruction addresses
  logic [`R5P_AW-1:0] rs1_q;
  logic [`R5P_AW-1:0] rs2_q;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // free in idle and during writeback
  assign busy   = (state == st_read) || (state == st_exec);
  assign accept = ins_valid & ~busy;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle, st_wb: state <= accept ? st_read : st_idle;  // wb can chain
        st_read:        state <= st_exec;
        st_exec:        if (cnt_zero) state <= st_wb;  // shift done
        default:        state <= st_idle;
      endcase
    end
  end

  // instruction fields, held until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q  <= op;
      rd_q  <= rd;
      rs1_q <= rs1;
      rs2_q <= rs2;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign cap  = (state == st_read);              // operands valid at end of read
  assign load = (state == st_read);              // counter loads with the capture
  assign step = (state == st_exec) & ~cnt_zero;  // one shift bit per cycle

  assign ret    = (state == st_wb);
  assign ret_rd = rd_q;

  // register file addresses come straight from the held fields
  assign rf.a_rs1 = rs1_q;
  assign rf.a_rs2 = rs2_q;
  assign rf.a_rd  = rd_q;
  assign rf.e_rs1 = (state == st_read);
  assign rf.e_rs2 = (state == st_read);
  assign rf.e_rd  = (state == st_wb);  // write lands on the edge leaving wb

endmodule : r5p_mini_ctl

`default_nettype wire

// File: design/r5p_mini_shcnt.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_shcnt (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,      // take a new shift amount
  input  logic                step,      // one bit shifted
  input  logic [`R5P_SHW-1:0] shamt,
  output logic                cnt_zero   // execute phase may end
);

  logic [`R5P_SHW-1:0] cnt;  // bits still to shift

  // down counter, bounds the execute phase
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (load) begin
      cnt <= shamt;  // zero for non-shift ops
    end else if (step && (cnt != '0)) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign cnt_zero = (cnt == '0);

endmodule : r5p_mini_shcnt

`default_nettype wire

// File: design/r5p_mini_alu.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_alu (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cap,    // operand capture, end of read phase
  input  logic                  step,   // shift by one bit
  input  r5p_mini_pkg::alu_op_t op,     // registered op from ctl
  input  logic                  use_imm,
  input  logic [11:0]           imm,
  output logic [`R5P_SHW-1:0]   shamt,
  r5p_mini_rf_if.alu            rf
);

  import r5p_mini_pkg::*;

  logic                 use_imm_q;
  logic [11:0]          imm_q;
  logic [`R5P_XLEN-1:0] imm_ext;  // sign extended immediate
  logic [`R5P_XLEN-1:0] opa;
  logic [`R5P_XLEN-1:0] opb;
  logic [`R5P_XLEN-1:0] res;      // result, also the shift register
  logic [`R5P_XLEN-1:0] res_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // operand selection
  ////////////////////////////////////////////////////////////////////////////

  // sampled every edge, cap always follows the accept edge by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      use_imm_q <= 1'b0;
    end else begin
      use_imm_q <= use_imm;
    end
  end

  always_ff @(posedge clk) begin
    imm_q <= imm;
  end

  assign imm_ext = {{(`R5P_XLEN-12){imm_q[11]}}, imm_q};
  assign opa     = rf.d_rs1;
  assign opb     = use_imm_q ? imm_ext : rf.d_rs2;

  // only shifts spend cycles in exec
  assign shamt = is_shift(op) ? opb[`R5P_SHW-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // single cycle ops
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      op_add:  res_nxt = opa + opb;
      op_sub:  res_nxt = opa - opb;
      op_and:  res_nxt = opa & opb;
      op_or:   res_nxt = opa | opb;
      op_xor:  res_nxt = opa ^ opb;
      op_slt:  res_nxt = {{(`R5P_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
      op_sltu: res_nxt = {{(`R5P_XLEN-1){1'b0}}, opa < opb};
      default: res_nxt = opa;  // shifts start from rs1
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // result and bit serial shifter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      res <= '0;
    end else if (cap) begin
      res <= res_nxt;
    end else if (step) begin
      case (op)
        op_sll:  res <= {res[`R5P_XLEN-2:0], 1'b0};
        op_sra:  res <= {res[`R5P_XLEN-1], res[`R5P_XLEN-1:1]};  // keep sign
        default: res <= {1'b0, res[`R5P_XLEN-1:1]};              // srl
      endcase
    end
  end

  assign rf.d_rd = res;  // writeback data, also the retire data

endmodule : r5p_mini_alu

`default_nettype wire

// File: design/r5p_mini_top.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_top (
  input  logic                  clk,
  input  logic                  reset,
  // instruction
  input  logic                  ins_valid,
  input  r5p_mini_pkg::alu_op_t op,
  input  logic [`R5P_AW-1:0]    rd,
  input  logic [`R5P_AW-1:0]    rs1,
  input  logic [`R5P_AW-1:0]    rs2,
  input  logic                  use_imm,
  input  logic [11:0]           imm,
  // status and retire
  output logic                  busy,
  output logic                  ret,
  output logic [`R5P_AW-1:0]    ret_rd,
  output logic [`R5P_XLEN-1:0]  ret_data
);

  import r5p_mini_pkg::*;

  alu_op_t             op_q;      // op of the instruction in flight
  logic                cap;
  logic                load;
  logic                step;
  logic                cnt_zero;
  logic [`R5P_SHW-1:0] shamt;

  r5p_mini_rf_if rf ();

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  r5p_mini_ctl ctl_i (
    .clk       (clk),
    .reset     (reset),
    .ins_valid (ins_valid),
    .op        (op),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .cnt_zero  (cnt_zero),
    .busy      (busy),
    .ret       (ret),
    .ret_rd    (ret_rd),
    .cap       (cap),
    .load      (load),
    .step      (step),
    .op_q      (op_q),
    .rf        (rf)
  );

  r5p_mini_shcnt shcnt_i (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .shamt    (shamt),
    .cnt_zero (cnt_zero)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  r5p_mini_gpr gpr_i (
    .clk   (clk),
    .reset (reset),
    .rf    (rf)
  );

  r5p_mini_alu alu_i (
    .clk     (clk),
    .reset   (reset),
    .cap     (cap),
    .step    (step),
    .op      (op_q),
    .use_imm (use_imm),
    .imm     (imm),
    .shamt   (shamt),
    .rf      (rf)
  );

  assign ret_data = rf.d_rd;  // qualified by ret

endmodule : r5p_mini_top

`default_nettype wire

// File: verification/r5p_mini_clkgen.sv
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_clkgen (
  output logic clk,
  output logic reset
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset spans 3 rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule : r5p_mini_clkgen

`default_nettype wire

// File: verification/r5p_mini_assert.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_assert (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       busy,
  input  logic                       ret,
  input  r5p_mini_pkg::ctl_state_t   state,  // sequencer state
  input  logic [`R5P_SHW-1:0]        cnt     // shift counter value
);

  import r5p_mini_pkg::*;

  logic [5:0] busy_len;  // cycles busy has been high, saturates

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_len <= '0;
    end else if (!busy) begin
      busy_len <= '0;
    end else if (busy_len != 6'd63) begin
      busy_len <= busy_len + 6'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  // retire is a single cycle pulse
  ret_single: assert property (@(posedge clk) disable iff (reset) ret |=> !ret)
    else $error("ret high on two consecutive cycles");

  // longest shift is well below this
  busy_bound: assert property (@(posedge clk) disable iff (reset) busy_len <= 6'd40)
    else $error("busy stayed high for more than 40 cycles");

  cnt_idle: assert property (@(posedge clk) disable iff (reset)
    (state != st_exec) |-> (cnt == '0))
    else $error("shift counter nonzero outside execute");

endmodule : r5p_mini_assert

bind r5p_mini_top r5p_mini_assert assert_i (
  .clk   (clk),
  .reset (reset),
  .busy  (busy),
  .ret   (ret),
  .state (ctl_i.state),
  .cnt   (shcnt_i.cnt)
);

`default_nettype wire

// File: verification/r5p_mini_tb.sv
`include "r5p_mini_cfg.svh"
`default_nettype none
`timescale 1ns/1ps

module r5p_mini_tb;

  import r5p_mini_pkg::*;

  typedef struct {
    alu_op_t     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        use_imm;
    logic [11:0] imm;
    logic [31:0] exp;    // expected ret_data
    int          grp;    // test number
    bit          chain;  // next entry presented while this one is busy
  } entry_t;

  logic clk, reset, ins_valid, use_imm, busy, ret;
  alu_op_t op;
  logic [`R5P_AW-1:0] rd, rs1, rs2, ret_rd;
  logic [11:0] imm;
  logic [`R5P_XLEN-1:0] ret_data;

  entry_t      tbl[$];
  logic [31:0] sh[32];      // shadow register file
  logic [31:0] rng;
  int          errors, checks, ntests;
  string       names[7];

  r5p_mini_clkgen clkgen_i (.clk(clk), .reset(reset));

  r5p_mini_top r5p_mini_top_i (
    .clk(clk), .reset(reset), .ins_valid(ins_valid), .op(op), .rd(rd),
    .rs1(rs1), .rs2(rs2), .use_imm(use_imm), .imm(imm), .busy(busy),
    .ret(ret), .ret_rd(ret_rd), .ret_data(ret_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference result from the operation rules
  function automatic logic [31:0] calc(alu_op_t o, logic [31:0] a, logic [31:0] b);
    case (o)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sltu: return (a < b) ? 32'd1 : 32'd0;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      default: return $unsigned($signed(a) >>> b[4:0]);  // sra
    endcase
  endfunction

  function automatic logic [31:0] opnd_b(entry_t e);
    return e.use_imm ? {{20{e.imm[11]}}, e.imm} : sh[e.rs2];
  endfunction

  task automatic add(int g, alu_op_t o, int d, int s1, int s2, bit ui,
                     logic [11:0] im, logic [31:0] ex, bit ch = 0);
    entry_t e;
    e.op = o;
    e.rd = 5'(d);
    e.rs1 = 5'(s1);
    e.rs2 = 5'(s2);
    e.use_imm = ui;
    e.imm = im;
    e.exp = ex;
    e.grp = g;
    e.chain = ch;
    tbl.push_back(e);
  endtask

  task automatic finish_run();
    $display("%0d tests run, %0d checks, %0d errors", ntests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic drive_fields(entry_t e);
    op = e.op;
    rd = e.rd;
    rs1 = e.rs1;
    rs2 = e.rs2;
    use_imm = e.use_imm;
    imm = e.imm;
  endtask

  // called on a falling edge, accept follows on the next rising edge
  task automatic issue(entry_t e);
    int n;
    n = 0;
    while (busy) begin
      @(negedge clk);
      n++;
      if (n > 60) begin
        $display("timeout waiting for busy to fall");
        errors++;
        finish_run();
      end
    end
    drive_fields(e);
    ins_valid = 1'b1;
  endtask

  // waits for ret of e, optionally presents nxt while busy
  task automatic retire(entry_t e, bit has_nxt, entry_t nxt);
    int lat, exp_lat;
    logic [31:0] b;
    b = opnd_b(e);
    exp_lat = (e.op inside {op_sll, op_srl, op_sra}) ? 2 + int'(b[4:0]) : 2;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (lat == 1) begin
        if (has_nxt) drive_fields(nxt);
        else ins_valid = 1'b0;
      end
      if (lat > 60) begin
        $display("timeout waiting for ret");
        errors++;
        finish_run();
      end
    end while (!ret);
    checks += 3;
    assert (ret_data == e.exp) else begin
      $display("Mismatch ret_data got %h exp %h", ret_data, e.exp);
      errors++;
    end
    assert (ret_rd == e.rd) else begin
      $display("Mismatch ret_rd got %h exp %h", ret_rd, e.rd);
      errors++;
    end
    // lat counts from the falling edge before accept, one more than cycles after it
    assert (lat - 1 == exp_lat) else begin
      $display("Mismatch ret latency got %h exp %h", lat - 1, exp_lat);
      errors++;
    end
    if (e.rd != 0) sh[e.rd] = e.exp;  // x0 stays zero
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    add(1, op_add, 3, 1, 2, 0, 12'h000, 32'h0);
    // loads, then reg and imm forms
    add(2, op_add, 1, 0, 0, 1, 12'h123, 32'h0000_0123);
    add(2, op_add, 2, 0, 0, 1, 12'hffb, 32'hffff_fffb);
    add(2, op_add, 4, 0, 0, 1, 12'h7ff, 32'h0000_07ff);
    add(2, op_add, 5, 1, 2, 0, 12'h000, 32'h0000_011e);
    add(2, op_sub, 5, 1, 2, 0, 12'h000, 32'h0000_0128);
    add(2, op_and, 5, 1, 2, 0, 12'h000, 32'h0000_0123);
    add(2, op_or, 5, 1, 2, 0, 12'h000, 32'hffff_fffb);
    add(2, op_xor, 5, 1, 2, 0, 12'h000, 32'hffff_fed8);
    add(2, op_slt, 5, 1, 2, 0, 12'h000, 32'h0);
    add(2, op_slt, 5, 2, 1, 0, 12'h000, 32'h1);
    add(2, op_sltu, 5, 1, 2, 0, 12'h000, 32'h1);
    add(2, op_add, 6, 1, 0, 1, 12'h7ff, 32'h0000_0922);
    add(2, op_sub, 6, 1, 0, 1, 12'h010, 32'h0000_0113);
    add(2, op_and, 6, 2, 0, 1, 12'h0f0, 32'h0000_00f0);
    add(2, op_or, 6, 1, 0, 1, 12'h800, 32'hffff_f923);
    add(2, op_xor, 6, 4, 0, 1, 12'hfff, 32'hffff_f800);
    add(2, op_slt, 6, 2, 0, 1, 12'h000, 32'h1);
    add(2, op_sltu, 6, 1, 0, 1, 12'hfff, 32'h1);
    add(2, op_sltu, 6, 2, 0, 1, 12'h001, 32'h0);
    // x0 write shows on ret_data only
    add(3, op_add, 0, 1, 0, 1, 12'h001, 32'h0000_0124);
    add(3, op_add, 7, 0, 1, 0, 12'h000, 32'h0000_0123);
    add(3, op_or, 7, 0, 0, 0, 12'h000, 32'h0);
    // shift amounts in x10..x13
    add(4, op_add, 10, 0, 0, 1, 12'h000, 32'd0);
    add(4, op_add, 11, 0, 0, 1, 12'h001, 32'd1);
    add(4, op_add, 12, 0, 0, 1, 12'h011, 32'd17);
    add(4, op_add, 13, 0, 0, 1, 12'h01f, 32'd31);
    add(4, op_sll, 14, 1, 0, 1, 12'h000, 32'h0000_0123);
    add(4, op_sll, 14, 1, 0, 1, 12'h001, 32'h0000_0246);
    add(4, op_sll, 14, 1, 0, 1, 12'h011, 32'h0246_0000);
    add(4, op_sll, 14, 1, 0, 1, 12'h01f, 32'h8000_0000);
    add(4, op_sll, 14, 2, 12, 0, 12'h000, 32'hfff6_0000);
    add(4, op_srl, 14, 2, 10, 0, 12'h000, 32'hffff_fffb);
    add(4, op_srl, 14, 2, 11, 0, 12'h000, 32'h7fff_fffd);
    add(4, op_srl, 14, 2, 12, 0, 12'h000, 32'h0000_7fff);
    add(4, op_srl, 14, 2, 13, 0, 12'h000, 32'h0000_0001);
    add(4, op_srl, 14, 1, 0, 1, 12'h001, 32'h0000_0091);
    add(4, op_sra, 14, 2, 10, 0, 12'h000, 32'hffff_fffb);
    add(4, op_sra, 14, 2, 11, 0, 12'h000, 32'hffff_fffd);
    add(4, op_sra, 14, 2, 12, 0, 12'h000, 32'hffff_ffff);
    add(4, op_sra, 14, 2, 13, 0, 12'h000, 32'hffff_ffff);
    add(4, op_sra, 14, 1, 0, 1, 12'h001, 32'h0000_0091);
    add(4, op_sra, 14, 1, 0, 1, 12'h011, 32'h0);
    // chained issue reads the value just written
    add(5, op_add, 15, 1, 0, 1, 12'h100, 32'h0000_0223, 1);
    add(5, op_add, 16, 15, 15, 0, 12'h000, 32'h0000_0446, 1);
    add(5, op_sub, 17, 16, 1, 0, 12'h000, 32'h0000_0323);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    entry_t e, dummy;
    int e0, n;
    bit pending;
    ins_valid = 1'b0;
    op = op_add;
    rd = '0;
    rs1 = '0;
    rs2 = '0;
    use_imm = 1'b0;
    imm = '0;
    errors = 0;
    checks = 0;
    ntests = 0;
    pending = 0;
    rng = 32'h2723_146c;
    dummy = '{op_add, 5'd0, 5'd0, 5'd0, 1'b0, 12'd0, 32'd0, 0, 1'b0};
    names = '{"", "reset state", "alu table", "register x0", "shifts",
              "back to back", "random"};
    for (int i = 0; i < 32; i++) sh[i] = '0;
    build_table();

    n = 0;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
      n++;
      if (n > 20) begin
        $display("timeout waiting for reset release");
        errors++;
        finish_run();
      end
    end
    e0 = errors;  // reset checks belong to test 1
    checks += 2;
    assert (busy == 1'b0) else begin
      $display("Mismatch busy got %h exp %h", busy, 1'b0);
      errors++;
    end
    assert (ret == 1'b0) else begin
      $display("Mismatch ret got %h exp %h", ret, 1'b0);
      errors++;
    end

    for (int t = 1; t <= 5; t++) begin
      if (t > 1) begin
        e0 = errors;
      end
      for (int i = 0; i < tbl.size(); i++) begin
        if (tbl[i].grp == t) begin
          if (!pending) issue(tbl[i]);
          pending = tbl[i].chain;
          retire(tbl[i], tbl[i].chain, tbl[i].chain ? tbl[i+1] : dummy);
        end
      end
      ntests++;
      $display("test %0d %s done, %0d errors", t, names[t], errors - e0);
    end

    // random sequence against the shadow model
    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      e.op = alu_op_t'(4'(rng % 10));
      e.rd = rng[8:4];
      e.rs1 = rng[13:9];
      e.rs2 = rng[18:14];
      e.use_imm = rng[19];
      rng = xorshift(rng);
      e.imm = rng[11:0];
      e.grp = 6;
      e.chain = 0;
      e.exp = calc(e.op, sh[e.rs1], opnd_b(e));
      issue(e);
      retire(e, 0, dummy);
    end
    ntests++;
    $display("test 6 %s done, %0d errors", names[6], errors - e0);
    finish_run();
  end

endmodule : r5p_mini_tb

`default_nettype wire

// File: r5p_mini.f
+incdir+design
design/r5p_mini_pkg.sv
design/r5p_mini_rf_if.sv
design/r5p_mini_gpr.sv
design/r5p_mini_ctl.sv
design/r5p_mini_shcnt.sv
design/r5p_mini_alu.sv
design/r5p_mini_top.sv
verification/r5p_mini_clkgen.sv
verification/r5p_mini_assert.sv
verification/r5p_mini_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the r5p_mini testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module r5p_mini_tb \
  -f r5p_mini.f \
  -Mdir obj_dir \
  -o Vr5p_mini_tb
if [ $? -ne 0 ]; then
  echo "build error"
  exit 1
fi

./obj_dir/Vr5p_mini_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
